// File: Makefile
# Verilator build for the self-test subsystem

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= selftest_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/arith_check.sv
/*
 * Arithmetic checker: LFSR operand pairs go through an adder, and a
 * subtractor must recover the second operand from the registered sum.
 */
module arith_check (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               start,
   input  logic                               fault,
   output selftest_status_pkg::block_status_t status
);

   logic running;
   logic v1;
   logic last1;
   logic last2;
   logic err;
   logic fault_q;
   logic busy;
   logic lfsr_fb;
   logic [selftest_cfg_pkg::arith_cnt_width-1:0]  step;
   logic [selftest_cfg_pkg::arith_lfsr_width-1:0] lfsr;
   logic [selftest_cfg_pkg::data_width-1:0]       op_a;
   logic [selftest_cfg_pkg::data_width-1:0]       op_b;
   logic [selftest_cfg_pkg::data_width-1:0]       sum_q;
   logic [selftest_cfg_pkg::data_width-1:0]       a_q;
   logic [selftest_cfg_pkg::data_width-1:0]       b_q;
   logic [selftest_cfg_pkg::data_width-1:0]       ref_b;

   // Upper and lower LFSR halves give the two operands
   assign op_a = lfsr[selftest_cfg_pkg::arith_lfsr_width-1:selftest_cfg_pkg::data_width];
   assign op_b = lfsr[selftest_cfg_pkg::data_width-1:0];

   // Taps for x^32 + x^22 + x^2 + x + 1
   assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

   // Still stepping or draining the compare pipeline
   assign busy = running | v1 | last2;

   // Injected fault flips the reference LSB
   assign ref_b = b_q ^ {{(selftest_cfg_pkg::data_width - 1){1'b0}}, fault_q};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running <= 1'b0;
         step    <= '0;
         v1      <= 1'b0;
         last1   <= 1'b0;
         last2   <= 1'b0;
         err     <= 1'b0;
         fault_q <= 1'b0;
         status  <= '0;
      end else begin
         // Pipeline tags follow the operand stage
         v1    <= running;
         last1 <= running && (step == selftest_cfg_pkg::arith_last);
         last2 <= last1;
         if (start && !busy) begin
            running <= 1'b1;
            step    <= '0;
            err     <= 1'b0;
            fault_q <= fault;
            status  <= '0;
         end else if (running) begin
            step <= step + 1'b1;
            if (step == selftest_cfg_pkg::arith_last) begin
               running <= 1'b0;
            end
         end
         // Subtract-based check, sticky on mismatch
         if (v1 && ((sum_q - a_q) != ref_b)) begin
            err <= 1'b1;
         end
         if (last2) begin
            status.done   <= 1'b1;
            status.passed <= ~err;
         end
      end
   end

   // Operand generator and adder stage
   always_ff @(posedge clk) begin
      if (start && !busy) begin
         lfsr <= selftest_cfg_pkg::arith_seed;
      end else if (running) begin
         lfsr <= {lfsr[selftest_cfg_pkg::arith_lfsr_width-2:0], lfsr_fb};
      end
      sum_q <= op_a + op_b;
      a_q   <= op_a;
      b_q   <= op_b;
   end

endmodule

// File: logic/clk_cross_check.sv
/*
 * Clock-crossing checker: a Gray counter on fastclk is synchronized
 * into clk, converted back to binary and checked for forward motion.
 */
module clk_cross_check (
   input  logic                               clk,
   input  logic                               fastclk,
   input  logic                               arst_n,
   input  logic                               start,
   input  logic                               fault,
   output selftest_status_pkg::block_status_t status
);

   // clk domain
   logic running;
   logic req;
   logic fault_q;
   logic err;
   logic have_prev;
   logic en_s1;
   logic en_s2;
   logic sample;
   logic bad;
   logic [selftest_cfg_pkg::cross_cnt_width-1:0] cnt;
   logic [selftest_cfg_pkg::cross_width-1:0]     gray_s1;
   logic [selftest_cfg_pkg::cross_width-1:0]     gray_s2;
   logic [selftest_cfg_pkg::cross_width-1:0]     bin_s;
   logic [selftest_cfg_pkg::cross_width-1:0]     prev;
   logic [selftest_cfg_pkg::cross_width-1:0]     diff;

   // fastclk domain
   logic req_f1;
   logic req_f2;
   logic en_f;
   logic [selftest_cfg_pkg::cross_width-1:0] cnt_f;
   logic [selftest_cfg_pkg::cross_width-1:0] cnt_nxt;
   logic [selftest_cfg_pkg::cross_width-1:0] gray_f;

   function automatic logic [selftest_cfg_pkg::cross_width-1:0] gray2bin(
      input logic [selftest_cfg_pkg::cross_width-1:0] g
   );
      logic [selftest_cfg_pkg::cross_width-1:0] b;
      b[selftest_cfg_pkg::cross_width-1] = g[selftest_cfg_pkg::cross_width-1];
      for (int i = selftest_cfg_pkg::cross_width - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   assign cnt_nxt = cnt_f + 1'b1;

   // Request in, Gray counter steps while the synced enable is high
   always_ff @(posedge fastclk or negedge arst_n) begin
      if (!arst_n) begin
         req_f1 <= 1'b0;
         req_f2 <= 1'b0;
         en_f   <= 1'b0;
         cnt_f  <= '0;
         gray_f <= '0;
      end else begin
         req_f1 <= req;
         req_f2 <= req_f1;
         en_f   <= req_f2;
         if (en_f) begin
            cnt_f  <= cnt_nxt;
            // Registered Gray output, one bit changes per step
            gray_f <= cnt_nxt ^ (cnt_nxt >> 1);
         end
      end
   end

   // Two-flop synchronizers back into clk
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         en_s1   <= 1'b0;
         en_s2   <= 1'b0;
         gray_s1 <= '0;
         gray_s2 <= '0;
      end else begin
         en_s1   <= en_f;
         en_s2   <= en_s1;
         gray_s1 <= gray_f;
         gray_s2 <= gray_s1;
      end
   end

   assign bin_s  = gray2bin(gray_s2);
   assign diff   = bin_s - prev;
   // Sample only once the counter is seen running
   assign sample = running & en_s2;
   // Reference is the expected distance sign, zero for forward motion
   assign bad    = have_prev && (diff[selftest_cfg_pkg::cross_width-1] != fault_q);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running   <= 1'b0;
         req       <= 1'b0;
         cnt       <= '0;
         have_prev <= 1'b0;
         err       <= 1'b0;
         fault_q   <= 1'b0;
         status    <= '0;
      end else if (start && !running) begin
         running   <= 1'b1;
         req       <= 1'b1;
         cnt       <= '0;
         have_prev <= 1'b0;
         err       <= 1'b0;
         fault_q   <= fault;
         status    <= '0;
      end else if (sample) begin
         have_prev <= 1'b1;
         cnt       <= cnt + 1'b1;
         err       <= err | bad;
         // Last sample drops the request and reports
         if (cnt == selftest_cfg_pkg::cross_last) begin
            running       <= 1'b0;
            req           <= 1'b0;
            status.done   <= 1'b1;
            status.passed <= ~(err | bad);
         end
      end
   end

   // Previous sample for the wrap-aware compare
   always_ff @(posedge clk) begin
      if (sample) begin
         prev <= bin_s;
      end
   end

endmodule

// File: logic/decode_check.sv
/*
 * Case-decode checker: every index is decoded to one-hot by a case
 * statement and encoded back by a priority encoder.
 */
module decode_check (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               start,
   input  logic                               fault,
   output selftest_status_pkg::block_status_t status
);

   logic running;
   logic v1;
   logic last1;
   logic last2;
   logic err;
   logic fault_q;
   logic busy;
   logic [selftest_cfg_pkg::decode_width-1:0] idx;
   logic [selftest_cfg_pkg::decode_width-1:0] idx_q;
   logic [selftest_cfg_pkg::decode_width-1:0] enc;
   logic [selftest_cfg_pkg::decode_width-1:0] ref_i;
   logic [selftest_cfg_pkg::decode_codes-1:0] onehot;
   logic [selftest_cfg_pkg::decode_codes-1:0] onehot_q;

   assign busy = running | v1 | last2;

   // Injected fault flips the pipelined index LSB
   assign ref_i = idx_q ^ {{(selftest_cfg_pkg::decode_width - 1){1'b0}}, fault_q};

   // One-hot decoder under test
   always_comb begin
      case (idx)
         4'h0:    onehot = 16'h0001;
         4'h1:    onehot = 16'h0002;
         4'h2:    onehot = 16'h0004;
         4'h3:    onehot = 16'h0008;
         4'h4:    onehot = 16'h0010;
         4'h5:    onehot = 16'h0020;
         4'h6:    onehot = 16'h0040;
         4'h7:    onehot = 16'h0080;
         4'h8:    onehot = 16'h0100;
         4'h9:    onehot = 16'h0200;
         4'hA:    onehot = 16'h0400;
         4'hB:    onehot = 16'h0800;
         4'hC:    onehot = 16'h1000;
         4'hD:    onehot = 16'h2000;
         4'hE:    onehot = 16'h4000;
         default: onehot = 16'h8000;
      endcase
   end

   // Priority encoder, highest set bit wins
   always_comb begin
      enc = '0;
      for (int i = 0; i < selftest_cfg_pkg::decode_codes; i++) begin
         if (onehot_q[i]) begin
            enc = selftest_cfg_pkg::decode_width'(i);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running <= 1'b0;
         idx     <= '0;
         v1      <= 1'b0;
         last1   <= 1'b0;
         last2   <= 1'b0;
         err     <= 1'b0;
         fault_q <= 1'b0;
         status  <= '0;
      end else begin
         v1    <= running;
         last1 <= running && (idx == selftest_cfg_pkg::decode_last);
         last2 <= last1;
         if (start && !busy) begin
            running <= 1'b1;
            idx     <= '0;
            err     <= 1'b0;
            fault_q <= fault;
            status  <= '0;
         end else if (running) begin
            idx <= idx + 1'b1;
            if (idx == selftest_cfg_pkg::decode_last) begin
               running <= 1'b0;
            end
         end
         // Round trip must return the index
         if (v1 && (enc != ref_i)) begin
            err <= 1'b1;
         end
         if (last2) begin
            status.done   <= 1'b1;
            status.passed <= ~err;
         end
      end
   end

   // Decode stage registers
   always_ff @(posedge clk) begin
      onehot_q <= onehot;
      idx_q    <= idx;
   end

endmodule

// File: logic/mem_check.sv
/*
 * Memory march checker: one pass writes an address-derived pattern into
 * a small inferred array, a second pass reads it back and compares.
 */
module mem_check (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               start,
   input  logic                               fault,
   output selftest_status_pkg::block_status_t status
);

   logic wr_act;
   logic rd_act;
   logic v1;
   logic last1;
   logic last2;
   logic err;
   logic fault_q;
   logic busy;
   logic [selftest_cfg_pkg::mem_addr_width-1:0] addr;
   logic [selftest_cfg_pkg::data_width-1:0]     rd_q;
   logic [selftest_cfg_pkg::data_width-1:0]     exp_q;
   logic [selftest_cfg_pkg::data_width-1:0]     ref_w;
   logic [selftest_cfg_pkg::data_width-1:0]     mem [selftest_cfg_pkg::mem_depth];

   // Address spread over the word, inverted copy in the middle
   function automatic logic [selftest_cfg_pkg::data_width-1:0] pattern(
      input logic [selftest_cfg_pkg::mem_addr_width-1:0] a
   );
      return selftest_cfg_pkg::mem_pattern ^ {1'b0, a, ~a, a};
   endfunction

   assign busy = wr_act | rd_act | v1 | last2;

   // Injected fault flips the expected LSB
   assign ref_w = exp_q ^ {{(selftest_cfg_pkg::data_width - 1){1'b0}}, fault_q};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_act  <= 1'b0;
         rd_act  <= 1'b0;
         addr    <= '0;
         v1      <= 1'b0;
         last1   <= 1'b0;
         last2   <= 1'b0;
         err     <= 1'b0;
         fault_q <= 1'b0;
         status  <= '0;
      end else begin
         // Read data valid one cycle after the read pass address
         v1    <= rd_act;
         last1 <= rd_act && (addr == selftest_cfg_pkg::mem_last);
         last2 <= last1;
         if (start && !busy) begin
            wr_act  <= 1'b1;
            addr    <= '0;
            err     <= 1'b0;
            fault_q <= fault;
            status  <= '0;
         end else if (wr_act) begin
            // Address wraps to zero for the read pass
            addr <= addr + 1'b1;
            if (addr == selftest_cfg_pkg::mem_last) begin
               wr_act <= 1'b0;
               rd_act <= 1'b1;
            end
         end else if (rd_act) begin
            addr <= addr + 1'b1;
            if (addr == selftest_cfg_pkg::mem_last) begin
               rd_act <= 1'b0;
            end
         end
         // Sticky mismatch flag
         if (v1 && (rd_q != ref_w)) begin
            err <= 1'b1;
         end
         if (last2) begin
            status.done   <= 1'b1;
            status.passed <= ~err;
         end
      end
   end

   // Array with registered read port
   always_ff @(posedge clk) begin
      if (wr_act) begin
         mem[addr] <= pattern(addr);
      end
      rd_q  <= mem[addr];
      exp_q <= pattern(addr);
   end

endmodule

// File: logic/selftest_cfg_pkg.sv
/*
 * Self-test configuration: block indices, widths, run lengths and seeds
 * used by every checker of the power-on self-test subsystem.
 */
package selftest_cfg_pkg;

   // Checker count and bit positions in status and fault mask
   localparam int num_blocks = 4;
   localparam int blk_arith  = 0;
   localparam int blk_mem    = 1;
   localparam int blk_decode = 2;
   localparam int blk_cross  = 3;

   // Arithmetic checker
   localparam int data_width       = 16;
   localparam int arith_steps      = 64;
   localparam int arith_cnt_width  = $clog2(arith_steps);
   localparam int arith_lfsr_width = 2 * data_width;
   localparam logic [arith_cnt_width-1:0] arith_last =
      arith_cnt_width'(arith_steps - 1);
   // Any nonzero start value works
   localparam logic [arith_lfsr_width-1:0] arith_seed = 32'h1D87_2B41;

   // Memory march checker
   localparam int mem_depth      = 32;
   localparam int mem_addr_width = 5;
   localparam logic [mem_addr_width-1:0] mem_last = mem_addr_width'(mem_depth - 1);
   // XOR constant for the address-derived data pattern
   localparam logic [data_width-1:0] mem_pattern = 16'hA55A;

   // Case-decode checker, one code per index value
   localparam int decode_width = 4;
   localparam int decode_codes = 1 << decode_width;
   localparam logic [decode_width-1:0] decode_last = decode_width'(decode_codes - 1);

   // Clock-crossing checker
   localparam int cross_width     = 6;
   localparam int cross_samples   = 40;
   localparam int cross_cnt_width = $clog2(cross_samples);
   localparam logic [cross_cnt_width-1:0] cross_last =
      cross_cnt_width'(cross_samples - 1);

endpackage

// File: logic/selftest_status_pkg.sv
/*
 * Self-test status types: per-checker result, combined status word
 * and fault-injection mask.
 */
package selftest_status_pkg;

   // One checker result
   // Cleared on an accepted start, then held once done rises
   typedef struct packed {
      logic done;
      logic passed;
   } block_status_t;

   // Arith in the low bits, crossing in the high bits
   // Same order as the block indices
   typedef struct packed {
      block_status_t crossing;
      block_status_t decode;
      block_status_t mem;
      block_status_t arith;
   } selftest_status_t;

   // One fault-injection bit per checker
   typedef struct packed {
      logic crossing;
      logic decode;
      logic mem;
      logic arith;
   } fault_mask_t;

endpackage

// File: logic/selftest_top.sv
/*
 * Power-on self-test top: starts all checkers together and reduces
 * their results into one done and one passed flag.
 */
module selftest_top (
   input  logic                                  clk,
   input  logic                                  fastclk,
   input  logic                                  arst_n,
   input  logic                                  start,
   input  selftest_status_pkg::fault_mask_t      fault_mask,
   output selftest_status_pkg::selftest_status_t status,
   output logic                                  done,
   output logic                                  passed
);

   logic [selftest_cfg_pkg::num_blocks-1:0] done_v;
   logic [selftest_cfg_pkg::num_blocks-1:0] pass_v;

   arith_check u_arith (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .fault  (fault_mask.arith),
      .status (status.arith)
   );

   mem_check u_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .fault  (fault_mask.mem),
      .status (status.mem)
   );

   decode_check u_decode (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .fault  (fault_mask.decode),
      .status (status.decode)
   );

   // Only checker with a second clock
   clk_cross_check u_cross (
      .clk     (clk),
      .fastclk (fastclk),
      .arst_n  (arst_n),
      .start   (start),
      .fault   (fault_mask.crossing),
      .status  (status.crossing)
   );

   // Gather per-block flags by block index
   assign done_v[selftest_cfg_pkg::blk_arith]  = status.arith.done;
   assign done_v[selftest_cfg_pkg::blk_mem]    = status.mem.done;
   assign done_v[selftest_cfg_pkg::blk_decode] = status.decode.done;
   assign done_v[selftest_cfg_pkg::blk_cross]  = status.crossing.done;

   assign pass_v[selftest_cfg_pkg::blk_arith]  = status.arith.passed;
   assign pass_v[selftest_cfg_pkg::blk_mem]    = status.mem.passed;
   assign pass_v[selftest_cfg_pkg::blk_decode] = status.decode.passed;
   assign pass_v[selftest_cfg_pkg::blk_cross]  = status.crossing.passed;

   // Overall pass only once every checker has finished
   assign done   = &done_v;
   assign passed = done & (&pass_v);

endmodule

// File: project.f
logic/selftest_cfg_pkg.sv
logic/selftest_status_pkg.sv
logic/arith_check.sv
logic/mem_check.sv
logic/decode_check.sv
logic/clk_cross_check.sv
logic/selftest_top.sv
sim/selftest_tb.sv

// File: sim/selftest_tb.sv
/*
 * Self-test subsystem testbench: table-driven runs with fault masks,
 * latency checks, an overlapping start and a cycle watchdog.
 */
module selftest_tb;

   // One table row with fault mask, expected status and top-level passed
   typedef struct packed {
      selftest_status_pkg::fault_mask_t      mask;
      selftest_status_pkg::selftest_status_t status;
      logic                                  passed;
   } test_row_t;

   localparam int fixed_rows    = 6;
   localparam int rand_rows     = 6;
   localparam int num_rows      = fixed_rows + rand_rows;
   localparam int reset_cycles  = 5;
   localparam int restart_delay = 10;
   localparam int hold_cycles   = 8;
   // Fixed latencies from the start-sampling edge
   localparam int arith_lat     = selftest_cfg_pkg::arith_steps + 2;
   localparam int mem_lat       = 2 * selftest_cfg_pkg::mem_depth + 2;
   localparam int decode_lat    = selftest_cfg_pkg::decode_codes + 2;
   localparam int longest_lat   = (arith_lat > mem_lat) ? arith_lat : mem_lat;
   // A crossing run restarted by the second start ends no earlier than this
   localparam int cross_bound   = restart_delay + 1 + selftest_cfg_pkg::cross_samples;
   // Table rows plus the overlapping-start run
   localparam int cycle_limit   = (num_rows + 1) * 2 * longest_lat + reset_cycles;
   localparam logic [15:0] lfsr_seed = 16'd43464;

   logic                                  clk;
   logic                                  fastclk;
   logic                                  arst_n;
   logic                                  start;
   selftest_status_pkg::fault_mask_t      fault_mask;
   selftest_status_pkg::selftest_status_t status;
   logic                                  done;
   logic                                  passed;

   test_row_t                                rows [num_rows];
   logic [15:0]                              lfsr;
   logic [selftest_cfg_pkg::num_blocks-1:0]  mask_bits;
   int                                       errors;
   int                                       tests;
   int                                       cycles;
   int                                       first;
   int                                       lat_arith;
   int                                       lat_mem;
   int                                       lat_decode;
   int                                       lat_cross;
   int                                       drops;
   logic                                     restart_hit;
   logic                                     held;

   selftest_top uut (
      .clk        (clk),
      .fastclk    (fastclk),
      .arst_n     (arst_n),
      .start      (start),
      .fault_mask (fault_mask),
      .status     (status),
      .done       (done),
      .passed     (passed)
   );

   // Main clock period 4 and fast clock period 2
   always #2 clk = ~clk;
   always #1 fastclk = ~fastclk;

   // Fibonacci LFSR with x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Every checker finishes; its passed is the inverse of its fault bit
   function automatic test_row_t expect_row(input selftest_status_pkg::fault_mask_t m);
      test_row_t r;
      r.mask                   = m;
      r.status.arith.done      = 1'b1;
      r.status.arith.passed    = ~m.arith;
      r.status.mem.done        = 1'b1;
      r.status.mem.passed      = ~m.mem;
      r.status.decode.done     = 1'b1;
      r.status.decode.passed   = ~m.decode;
      r.status.crossing.done   = 1'b1;
      r.status.crossing.passed = ~m.crossing;
      r.passed                 = ~|m;
      return r;
   endfunction

   task automatic check_status(input string name,
                               input selftest_status_pkg::selftest_status_t got,
                               input selftest_status_pkg::selftest_status_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_latency(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAILED %s: got 0x%0h cycles, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: mismatch", tests, name);
      end
   endtask

   // Pulses start, optionally a second one, and follows the run to top-level done
   task automatic start_and_wait(input selftest_status_pkg::fault_mask_t mask,
                                 input int restart_at);
      int k;
      logic [selftest_cfg_pkg::num_blocks-1:0] prev_done;
      logic [selftest_cfg_pkg::num_blocks-1:0] cur_done;
      k           = 0;
      lat_arith   = -1;
      lat_mem     = -1;
      lat_decode  = -1;
      lat_cross   = -1;
      drops       = 0;
      restart_hit = 1'b0;
      @(negedge clk);
      fault_mask = mask;
      start      = 1'b1;
      @(negedge clk);
      start     = 1'b0;
      prev_done = {status.crossing.done, status.decode.done,
                   status.mem.done, status.arith.done};
      while (!done) begin
         @(negedge clk);
         k++;
         start = (k == restart_at);
         if (k == restart_at) begin
            restart_hit = ~status.crossing.done;
         end
         if (status.arith.done && lat_arith < 0) begin
            lat_arith = k;
         end
         if (status.mem.done && lat_mem < 0) begin
            lat_mem = k;
         end
         if (status.decode.done && lat_decode < 0) begin
            lat_decode = k;
         end
         if (status.crossing.done && lat_cross < 0) begin
            lat_cross = k;
         end
         // A falling done bit means a checker restarted mid-run
         cur_done = {status.crossing.done, status.decode.done,
                     status.mem.done, status.arith.done};
         if (|(prev_done & ~cur_done)) begin
            drops++;
         end
         prev_done = cur_done;
      end
      start = 1'b0;
   endtask

   // Watchdog on total run length
   initial begin
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: top-level done did not rise within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      fastclk    = 1'b0;
      arst_n     = 1'b0;
      start      = 1'b0;
      fault_mask = '0;
      errors     = 0;
      tests      = 0;
      lfsr       = lfsr_seed;

      // Row fields are fault mask {cross,decode,mem,arith}, expected status and top passed
      rows[0] = {4'b0000, 8'hFF, 1'b1};
      rows[1] = {4'b0001, 8'hFE, 1'b0};
      rows[2] = {4'b0010, 8'hFB, 1'b0};
      rows[3] = {4'b0100, 8'hEF, 1'b0};
      rows[4] = {4'b1000, 8'hBF, 1'b0};
      rows[5] = {4'b1111, 8'hAA, 1'b0};
      // Random masks with one LFSR step per mask bit
      for (int r = fixed_rows; r < num_rows; r++) begin
         for (int b = 0; b < selftest_cfg_pkg::num_blocks; b++) begin
            lfsr         = lfsr_next(lfsr);
            mask_bits[b] = lfsr[0];
         end
         rows[r] = expect_row(mask_bits);
      end

      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Idle after reset before any start
      first = errors;
      repeat (2) @(negedge clk);
      check_status("status", status, '0);
      check_flag("done", done, 1'b0);
      check_flag("passed", passed, 1'b0);
      report_test("idle after reset", first);

      for (int r = 0; r < num_rows; r++) begin
         first = errors;
         start_and_wait(rows[r].mask, 0);
         check_status("status", status, rows[r].status);
         check_flag("passed", passed, rows[r].passed);
         check_latency("status.arith.done latency", lat_arith, arith_lat);
         check_latency("status.mem.done latency", lat_mem, mem_lat);
         check_latency("status.decode.done latency", lat_decode, decode_lat);
         check_flag("status done bit dropped", drops != 0, 1'b0);
         report_test($sformatf("row %0d mask 0x%h", r, rows[r].mask), first);
      end

      // Second start while the crossing checker is busy must be ignored
      first = errors;
      start_and_wait('0, restart_delay);
      if (!restart_hit) begin
         $display("Crossing checker had already finished when the second start was sent");
         errors++;
      end
      held = 1'b1;
      repeat (hold_cycles) begin
         @(negedge clk);
         if (!done) begin
            held = 1'b0;
         end
      end
      check_status("status", status, 8'hFF);
      check_flag("passed", passed, 1'b1);
      check_flag("done held after completion", held, 1'b1);
      check_flag("status done bit dropped", drops != 0, 1'b0);
      check_latency("status.arith.done latency", lat_arith, arith_lat);
      check_latency("status.mem.done latency", lat_mem, mem_lat);
      check_latency("status.decode.done latency", lat_decode, decode_lat);
      if (lat_cross >= cross_bound) begin
         $display("FAILED status.crossing.done latency: got 0x%0h cycles, limit 0x%0h",
                  lat_cross, cross_bound);
         errors++;
      end
      report_test("second start during crossing run", first);

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
